// File: verilog/soc_pkg.sv
package soc_pkg;

   //////////////////////////////////////////////////////////////////////
   // native bus base types
   //////////////////////////////////////////////////////////////////////

   // byte address as issued by the master
   typedef logic [31:0] addr_t;

   // one bus word
   typedef logic [31:0] data_t;

   // one strobe per byte lane
   // all zero means a read
   typedef logic [3:0] strb_t;

   //////////////////////////////////////////////////////////////////////
   // request and response bundles
   //////////////////////////////////////////////////////////////////////

   // master to slave, 69 bits
   // valid held with stable payload until ready is seen
   typedef struct packed {
      logic  valid;
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } native_req_t;

   // slave to master, 33 bits
   // ready is a single-cycle pulse, rdata valid with it
   typedef struct packed {
      logic  ready;
      data_t rdata;
   } native_rsp_t;

   //////////////////////////////////////////////////////////////////////
   // decode and soft reset
   //////////////////////////////////////////////////////////////////////

   // target of the current request
   typedef enum logic [0:0] {
      slave_boot = 1'b0,
      slave_main = 1'b1
   } slave_sel_t;

   // any valid access here fires the soft reset
   // bit 31 is set, so main memory answers the access itself
   localparam addr_t soft_reset_addr = 32'hffff_fffc;

   // length of the rotating soft-reset register
   localparam int soft_reset_w = 5;

endpackage

// File: verilog/por_counter.sv
module por_counter #(
   parameter int por_cnt_w = 11
) (
   input  logic clk,
   input  logic reset,
   output logic sys_resetn
);

   // free-running until the top bit sets, then frozen
   logic [por_cnt_w-1:0] cnt;

   //////////////////////////////////////////////////////////////////////
   // power-on count
   //////////////////////////////////////////////////////////////////////

   // cleared by the external reset
   // top bit sets 2**(por_cnt_w-1) edges after reset falls
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         cnt <= '0;
      end else if (!cnt[por_cnt_w-1]) begin
         // still counting
         cnt <= cnt + por_cnt_w'(1);
      end
   end

   // top bit is the internal active-low reset
   // low through reset and the whole count
   assign sys_resetn = cnt[por_cnt_w-1];

endmodule

// File: verilog/soft_reset_ctrl.sv
module soft_reset_ctrl (
   input  logic                 clk,
   input  logic                 sys_resetn,
   input  soc_pkg::native_req_t bus_req,
   output logic                 mem_sel,
   output logic                 cpu_reset
);

   localparam int rot_w = soc_pkg::soft_reset_w;

   // idle pattern, single one in the top position
   localparam logic [rot_w-1:0] rot_idle = {1'b1, {(rot_w - 1){1'b0}}};

   // rotating soft-reset register
   logic [rot_w-1:0] rot;

   // valid request at the soft-reset address
   logic hit;

   //////////////////////////////////////////////////////////////////////
   // request compare
   //////////////////////////////////////////////////////////////////////

   // full 32-bit compare, reads and writes alike
   assign hit = bus_req.valid && (bus_req.addr == soc_pkg::soft_reset_addr);

   //////////////////////////////////////////////////////////////////////
   // switch flag and rotate
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!sys_resetn) begin
         // back to boot memory
         rot     <= rot_idle;
         mem_sel <= 1'b0;
      end else if (hit) begin
         // rotate left once per edge while the request stays up
         // first edge moves the one into bit 0
         rot     <= {rot[rot_w-2:0], rot[rot_w-1]};
         // sticky until the next system reset
         mem_sel <= 1'b1;
      end else begin
         // no access, park the pattern
         rot <= rot_idle;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // processor reset
   //////////////////////////////////////////////////////////////////////

   // bit 0 high only in the cycle after the first hit edge
   // a two-cycle access rotates it out again on the second edge
   // system reset keeps the processor held as well
   assign cpu_reset = rot[0] | ~sys_resetn;

endmodule

// File: verilog/native_interconnect.sv
module native_interconnect (
   input  logic                   mem_sel,
   input  soc_pkg::native_req_t   bus_req,
   output soc_pkg::native_rsp_t   bus_rsp,
   output soc_pkg::native_req_t   boot_req,
   input  soc_pkg::native_rsp_t   boot_rsp,
   output soc_pkg::native_req_t   main_req,
   input  soc_pkg::native_rsp_t   main_rsp,
   output soc_pkg::slave_sel_t    s_sel
);

   // address bit 31 of the request
   logic hi_region;

   // one-hot enables, derived from s_sel
   logic boot_en;
   logic main_en;

   //////////////////////////////////////////////////////////////////////
   // address decode
   //////////////////////////////////////////////////////////////////////

   assign hi_region = bus_req.addr[31];

   // upper half always goes to main memory
   // lower half goes to boot until the switch flag is up
   always_comb begin
      if (hi_region || mem_sel) begin
         s_sel = soc_pkg::slave_main;
      end else begin
         s_sel = soc_pkg::slave_boot;
      end
   end

   assign boot_en = (s_sel == soc_pkg::slave_boot);
   assign main_en = (s_sel == soc_pkg::slave_main);

   //////////////////////////////////////////////////////////////////////
   // request fan-out
   //////////////////////////////////////////////////////////////////////

   // payload goes to both slaves unchanged
   // only the selected one sees valid
   always_comb begin
      boot_req       = bus_req;
      boot_req.valid = bus_req.valid && boot_en;
   end

   always_comb begin
      main_req       = bus_req;
      main_req.valid = bus_req.valid && main_en;
   end

   //////////////////////////////////////////////////////////////////////
   // response steering
   //////////////////////////////////////////////////////////////////////

   // master holds the request through the ready cycle
   // so the select is still valid when the answer comes back
   always_comb begin
      if (main_en) begin
         bus_rsp = main_rsp;
      end else begin
         bus_rsp = boot_rsp;
      end
   end

endmodule

// File: verilog/native_ram.sv
module native_ram #(
   parameter int addr_w = 14
) (
   input  logic                 clk,
   input  logic                 sys_resetn,
   input  soc_pkg::native_req_t req,
   output soc_pkg::native_rsp_t rsp
);

   localparam int depth   = 2 ** (addr_w - 2);
   localparam int n_lanes = $bits(soc_pkg::strb_t);

   // word storage, contents start undefined
   soc_pkg::data_t mem [depth];

   // word index from the byte address
   // upper address bits ignored, so the region aliases
   logic [addr_w-3:0] word_idx;

   // request already taken, waiting for valid to drop
   logic acked;

   // first cycle of a request
   logic first;

   // registered response
   logic           ready_q;
   soc_pkg::data_t rdata_q;

   assign word_idx = req.addr[addr_w-1:2];
   assign first    = req.valid && !acked;

   //////////////////////////////////////////////////////////////////////
   // handshake
   //////////////////////////////////////////////////////////////////////

   // ready one cycle after the first valid cycle, for one cycle
   // acked clears once the master drops valid
   always_ff @(posedge clk) begin
      if (!sys_resetn) begin
         acked   <= 1'b0;
         ready_q <= 1'b0;
      end else begin
         acked   <= req.valid;
         ready_q <= first;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // storage access
   //////////////////////////////////////////////////////////////////////

   // read and write on the first edge only
   // read returns the old word on a write
   always_ff @(posedge clk) begin
      if (first) begin
         rdata_q <= mem[word_idx];
         // strobed byte lanes
         for (int b = 0; b < n_lanes; b++) begin
            if (req.wstrb[b]) begin
               mem[word_idx][8*b +: 8] <= req.wdata[8*b +: 8];
            end
         end
      end
   end

   // rdata only meaningful with ready
   assign rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

// File: verilog/soc_fabric.sv
module soc_fabric #(
   parameter int por_cnt_w   = 11,
   parameter int boot_addr_w = 14,
   parameter int main_addr_w = 14
) (
   input  logic                 clk,
   input  logic                 reset,
   // native master port, driven from outside
   input  soc_pkg::native_req_t bus_req,
   output soc_pkg::native_rsp_t bus_rsp,
   // reset and status
   output logic                 sys_resetn,
   output logic                 cpu_reset,
   output logic                 mem_sel,
   output soc_pkg::slave_sel_t  s_sel
);

   //////////////////////////////////////////////////////////////////////
   // slave side wires
   //////////////////////////////////////////////////////////////////////

   // boot memory
   soc_pkg::native_req_t boot_req;
   soc_pkg::native_rsp_t boot_rsp;

   // main memory
   soc_pkg::native_req_t main_req;
   soc_pkg::native_rsp_t main_rsp;

   //////////////////////////////////////////////////////////////////////
   // reset chain
   //////////////////////////////////////////////////////////////////////

   // external reset in, internal reset out
   por_counter #(
      .por_cnt_w (por_cnt_w)
   ) u_por (
      .clk        (clk),
      .reset      (reset),
      .sys_resetn (sys_resetn)
   );

   // boot to main switch and processor reset pulse
   soft_reset_ctrl u_soft_reset (
      .clk        (clk),
      .sys_resetn (sys_resetn),
      .bus_req    (bus_req),
      .mem_sel    (mem_sel),
      .cpu_reset  (cpu_reset)
   );

   //////////////////////////////////////////////////////////////////////
   // interconnect
   //////////////////////////////////////////////////////////////////////

   native_interconnect u_interconnect (
      .mem_sel  (mem_sel),
      .bus_req  (bus_req),
      .bus_rsp  (bus_rsp),
      .boot_req (boot_req),
      .boot_rsp (boot_rsp),
      .main_req (main_req),
      .main_rsp (main_rsp),
      .s_sel    (s_sel)
   );

   //////////////////////////////////////////////////////////////////////
   // memories
   //////////////////////////////////////////////////////////////////////

   // boot memory, slave 0
   native_ram #(
      .addr_w (boot_addr_w)
   ) u_boot_ram (
      .clk        (clk),
      .sys_resetn (sys_resetn),
      .req        (boot_req),
      .rsp        (boot_rsp)
   );

   // main memory, slave 1, also answers the soft-reset access
   native_ram #(
      .addr_w (main_addr_w)
   ) u_main_ram (
      .clk        (clk),
      .sys_resetn (sys_resetn),
      .req        (main_req),
      .rsp        (main_rsp)
   );

endmodule

// File: bench/soc_fabric_model.sv
module soc_fabric_model #(
   parameter int por_cnt_w   = 11,
   parameter int boot_addr_w = 14,
   parameter int main_addr_w = 14
);

   timeunit 1ns;
   timeprecision 1ps;

   // word contents and written byte lanes, keyed by word index
   soc_pkg::data_t boot_mem   [int unsigned];
   soc_pkg::strb_t boot_known [int unsigned];
   soc_pkg::data_t main_mem   [int unsigned];
   soc_pkg::strb_t main_known [int unsigned];

   // boot to main switch as seen by the decoder
   logic mem_sel_q;

   // rising edges from reset release to sys_resetn high
   function automatic int por_edges();
      return 2 ** (por_cnt_w - 1);
   endfunction

   // upper half always main, lower half follows the switch
   function automatic soc_pkg::slave_sel_t decode(soc_pkg::addr_t addr);
      if (addr[31] == 1'b1) begin
         return soc_pkg::slave_main;
      end
      if (mem_sel_q == 1'b1) begin
         return soc_pkg::slave_main;
      end
      return soc_pkg::slave_boot;
   endfunction

   // word index inside a RAM of aw byte-address bits
   function automatic int unsigned word_index(soc_pkg::addr_t addr, int aw);
      soc_pkg::addr_t idx_mask;
      idx_mask = (32'd1 << (aw - 2)) - 32'd1;
      return (addr >> 2) & idx_mask;
   endfunction

   // strobe bits widened to byte masks
   function automatic soc_pkg::data_t lane_mask(soc_pkg::strb_t s);
      soc_pkg::data_t m;
      for (int b = 0; b < $bits(soc_pkg::strb_t); b++) begin
         m[8*b +: 8] = {8{s[b]}};
      end
      return m;
   endfunction

   function automatic soc_pkg::data_t merge(soc_pkg::data_t old_word,
                                            soc_pkg::data_t wdata,
                                            soc_pkg::strb_t wstrb);
      soc_pkg::data_t m;
      m = lane_mask(wstrb);
      return (old_word & ~m) | (wdata & m);
   endfunction

   // one bus access
   // mask marks the rdata bits that are worth comparing
   task automatic access(input  soc_pkg::addr_t      addr,
                         input  soc_pkg::data_t      wdata,
                         input  soc_pkg::strb_t      wstrb,
                         output soc_pkg::native_rsp_t exp,
                         output soc_pkg::data_t      mask,
                         output soc_pkg::slave_sel_t sel);
      int unsigned    idx;
      soc_pkg::data_t old_word;
      soc_pkg::strb_t known;
      sel      = decode(addr);
      old_word = '0;
      known    = '0;
      if (sel == soc_pkg::slave_main) begin
         idx = word_index(addr, main_addr_w);
         if (main_mem.exists(idx)) begin
            old_word = main_mem[idx];
            known    = main_known[idx];
         end
         if (wstrb != '0) begin
            main_mem[idx]   = merge(old_word, wdata, wstrb);
            main_known[idx] = known | wstrb;
         end
      end else begin
         idx = word_index(addr, boot_addr_w);
         if (boot_mem.exists(idx)) begin
            old_word = boot_mem[idx];
            known    = boot_known[idx];
         end
         if (wstrb != '0) begin
            boot_mem[idx]   = merge(old_word, wdata, wstrb);
            boot_known[idx] = known | wstrb;
         end
      end
      exp.ready = 1'b1;
      exp.rdata = old_word;
      // only reads carry defined data
      mask = (wstrb == '0) ? lane_mask(known) : '0;
      // soft-reset access flips the decoder
      if (addr == soc_pkg::soft_reset_addr) begin
         mem_sel_q = 1'b1;
      end
   endtask

   // system reset returns to boot memory, contents kept
   task automatic clear_switch();
      mem_sel_q = 1'b0;
   endtask

endmodule

// File: bench/soc_fabric_tb.sv
module soc_fabric_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int por_cnt_w   = 6;
   localparam int boot_addr_w = 14;
   localparam int main_addr_w = 14;

   // run length
   localparam int reset_hold  = 2;
   localparam int n_pre       = 200;
   localparam int n_post      = 120;
   localparam int n_tail      = 40;
   localparam int n_trans     = n_pre + 1 + n_post + n_tail;
   localparam int ready_limit = 8;

   // two power-on sequences plus all accesses
   localparam int por_len         = reset_hold + 2 ** (por_cnt_w - 1);
   localparam int watchdog_cycles = 2 * por_len + n_trans * 4 + 200;

   logic                 clk;
   logic                 reset;
   soc_pkg::native_req_t bus_req;
   soc_pkg::native_rsp_t bus_rsp;
   logic                 sys_resetn;
   logic                 cpu_reset;
   logic                 mem_sel;
   soc_pkg::slave_sel_t  s_sel;

   // xorshift state
   logic [31:0] rng;

   soc_fabric #(
      .por_cnt_w   (por_cnt_w),
      .boot_addr_w (boot_addr_w),
      .main_addr_w (main_addr_w)
   ) u_soc_fabric (
      .clk        (clk),
      .reset      (reset),
      .bus_req    (bus_req),
      .bus_rsp    (bus_rsp),
      .sys_resetn (sys_resetn),
      .cpu_reset  (cpu_reset),
      .mem_sel    (mem_sel),
      .s_sel      (s_sel)
   );

   soc_fabric_model #(
      .por_cnt_w   (por_cnt_w),
      .boot_addr_w (boot_addr_w),
      .main_addr_w (main_addr_w)
   ) u_model ();

   //////////////////////////////////////////////////////////////////////
   // clock and watchdog
   //////////////////////////////////////////////////////////////////////

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
      $display("STATUS: FAIL");
      $fatal(1, "watchdog timeout");
   end

   //////////////////////////////////////////////////////////////////////
   // helpers and compares
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] rand_word();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   task automatic stop_run(string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_level(logic got, logic exp, string what);
      if (got !== exp) begin
         stop_run($sformatf("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp));
      end
   endtask

   task automatic check_sel(soc_pkg::slave_sel_t got, soc_pkg::slave_sel_t exp, string what);
      if (got !== exp) begin
         stop_run($sformatf("MISMATCH at %0t: %s is %s, expected %s",
                            $time, what, got.name(), exp.name()));
      end
   endtask

   task automatic check_rsp(soc_pkg::native_rsp_t got, soc_pkg::native_rsp_t exp,
                            soc_pkg::data_t mask, string what);
      if (got.ready !== exp.ready) begin
         stop_run($sformatf("MISMATCH at %0t: %s ready is %b, expected %b",
                            $time, what, got.ready, exp.ready));
      end
      if ((got.rdata & mask) !== (exp.rdata & mask)) begin
         stop_run($sformatf("MISMATCH at %0t: %s rdata %h, expected %h under mask %h",
                            $time, what, got.rdata, exp.rdata, mask));
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // sequences
   //////////////////////////////////////////////////////////////////////

   // reset pulse, then the power-on count edge by edge
   task automatic power_on_sequence();
      int edges;
      edges = u_model.por_edges();
      @(negedge clk);
      reset = 1'b1;
      u_model.clear_switch();
      repeat (reset_hold) begin
         @(negedge clk);
         check_level(sys_resetn, 1'b0, "sys_resetn in reset");
         check_level(cpu_reset, 1'b1, "cpu_reset in reset");
         check_level(mem_sel, 1'b0, "mem_sel in reset");
      end
      reset = 1'b0;
      for (int i = 1; i <= edges; i++) begin
         @(negedge clk);
         check_level(sys_resetn, i == edges, "sys_resetn during count");
         check_level(cpu_reset, i != edges, "cpu_reset during count");
         check_level(mem_sel, 1'b0, "mem_sel during count");
         check_level(bus_rsp.ready, 1'b0, "ready during count");
      end
   endtask

   // one access entered and left on a falling edge
   task automatic run_access(soc_pkg::addr_t addr, soc_pkg::data_t wdata,
                             soc_pkg::strb_t wstrb);
      soc_pkg::native_rsp_t exp_rsp;
      soc_pkg::data_t       mask;
      soc_pkg::slave_sel_t  exp_sel;
      logic                 is_soft;
      logic                 exp_mem_sel;
      int                   cycles;
      is_soft = (addr == soc_pkg::soft_reset_addr);
      u_model.access(addr, wdata, wstrb, exp_rsp, mask, exp_sel);
      exp_mem_sel = u_model.mem_sel_q;
      bus_req = '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
      cycles  = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (!bus_rsp.ready && cycles < ready_limit);
      if (!bus_rsp.ready) begin
         stop_run($sformatf("no ready from the fabric for address %h", addr));
      end
      if (cycles != 1) begin
         stop_run($sformatf("MISMATCH at %0t: ready after %0d cycles, expected 1",
                            $time, cycles));
      end
      check_rsp(bus_rsp, exp_rsp, mask, $sformatf("access to %h", addr));
      check_sel(s_sel, exp_sel, $sformatf("s_sel for %h", addr));
      check_level(cpu_reset, is_soft, "cpu_reset in ready cycle");
      check_level(mem_sel, exp_mem_sel, "mem_sel in ready cycle");
      // valid held until ready is taken on the next rising edge
      @(negedge clk);
      check_level(bus_rsp.ready, 1'b0, "ready after the pulse");
      check_level(cpu_reset, 1'b0, "cpu_reset after the access");
      check_level(mem_sel, exp_mem_sel, "mem_sel after the access");
      // master drops valid for a cycle
      bus_req.valid = 1'b0;
      @(negedge clk);
      check_level(bus_rsp.ready, 1'b0, "ready while idle");
   endtask

   // random word in one half with random upper bits so regions alias
   task automatic random_access(logic hi);
      logic [31:0]    r_addr;
      logic [31:0]    r_ctl;
      soc_pkg::addr_t addr;
      soc_pkg::data_t wdata;
      soc_pkg::strb_t wstrb;
      r_addr   = rand_word();
      r_ctl    = rand_word();
      wdata    = rand_word();
      // 32 words per region keep reads hitting written data
      addr     = (r_addr & 32'h7fff_c000) | ((r_ctl & 32'h0000_001f) << 2);
      addr[31] = hi;
      wstrb    = r_ctl[8] ? r_ctl[15:12] : 4'b0000;
      run_access(addr, wdata, wstrb);
   endtask

   //////////////////////////////////////////////////////////////////////
   // main flow
   //////////////////////////////////////////////////////////////////////

   initial begin
      logic [31:0] r;
      rng     = 32'hfbb1fd2b;
      reset   = 1'b1;
      bus_req = '0;
      power_on_sequence();
      // boot and main side by side
      repeat (n_pre) begin
         r = rand_word();
         random_access(r[0]);
      end
      // soft reset by a read at the register address
      run_access(soc_pkg::soft_reset_addr, '0, '0);
      // lower half now lands in main memory
      repeat (n_post) begin
         r = rand_word();
         random_access(r[3:0] == 4'h0);
      end
      // second power-on returns to boot memory
      power_on_sequence();
      repeat (n_tail) begin
         random_access(1'b0);
      end
      $display("STATUS: PASS");
      $finish;
   end

endmodule

// File: flist.f
verilog/soc_pkg.sv
verilog/por_counter.sv
verilog/soft_reset_ctrl.sv
verilog/native_interconnect.sv
verilog/native_ram.sv
verilog/soc_fabric.sv
bench/soc_fabric_model.sv
bench/soc_fabric_tb.sv

// File: run.sh
#!/bin/sh
# build and run the fabric testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
   --top-module soc_fabric_tb -f flist.f

status=0
out=$(./obj_dir/Vsoc_fabric_tb 2>&1) || status=$?
printf '%s\n' "$out"

if [ "$status" -eq 0 ] && printf '%s\n' "$out" | grep -qx 'STATUS: PASS'; then
   exit 0
fi

echo "simulation did not pass"
exit 1
